// ==== include/alu_macros.svh ====
`ifndef ALU_MACROS_SVH
`define ALU_MACROS_SVH

// Datapath width, fixed by the architecture
`define ALU_WIDTH 8

// One BCD digit
`define ALU_NIBBLE 4

// Digits above this value need a decimal correction
`define ALU_BCD_MAX 9

`endif

// ==== logic/alu_pkg.sv ====
`default_nettype none

`include "alu_macros.svh"

package alu_pkg;

	typedef enum logic [2:0] {
		op_and,
		op_or,
		op_eor,
		op_sum,
		op_sr
	} alu_op_t;

	// B input source
	typedef enum logic [1:0] {
		bsrc_db,
		bsrc_ndb, // inverted data bus, used for subtract
		bsrc_adl
	} alu_bsrc_t;

	typedef struct packed {
		alu_op_t op;
		logic    decimal_add;
		logic    decimal_sub;
		logic    ac_load;
	} alu_ctrl_t;

	typedef struct packed {
		logic [`ALU_WIDTH-1:0] ai;
		logic [`ALU_WIDTH-1:0] bi;
	} alu_operands_t;

	typedef struct packed {
		logic [`ALU_WIDTH-1:0] res;
		logic                  half_carry; // carry out of bit 3, DC3 included
		logic                  avr;
	} alu_sum_t;

endpackage

`default_nettype wire

// ==== logic/alu_stage_if.sv ====
`default_nettype none

interface alu_stage_if #(
	parameter type data_t = logic
) ();
	import alu_pkg::*;

	logic      valid;
	data_t     data;
	alu_ctrl_t ctrl;
	logic      carry; // carry_in or acr, depending on the stage

	modport src (
		output valid,
		output data,
		output ctrl,
		output carry
	);

	modport dst (
		input valid,
		input data,
		input ctrl,
		input carry
	);

endinterface

`default_nettype wire

// ==== logic/alu_operand_latch.sv ====
`default_nettype none

`include "alu_macros.svh"

module alu_operand_latch (
	input  logic                  phi2,
	input  logic                  arst_n,
	input  logic                  op_strobe,
	input  alu_pkg::alu_op_t      op,
	input  logic                  ai_zero,
	input  alu_pkg::alu_bsrc_t    bsrc,
	input  logic [`ALU_WIDTH-1:0] sb,
	input  logic [`ALU_WIDTH-1:0] db,
	input  logic [`ALU_WIDTH-1:0] adl,
	input  logic                  carry_in,
	input  logic                  decimal_add,
	input  logic                  decimal_sub,
	input  logic                  ac_load,
	alu_stage_if.src              out
);
	import alu_pkg::*;

	alu_operands_t operands_d;
	alu_ctrl_t     ctrl_d;

	always_comb begin
		operands_d.ai = ai_zero ? '0 : sb;
		case (bsrc)
			bsrc_db:  operands_d.bi = db;
			bsrc_ndb: operands_d.bi = ~db;
			bsrc_adl: operands_d.bi = adl;
			default:  operands_d.bi = db; // unused code
		endcase
	end

	always_comb begin
		ctrl_d.op          = op;
		ctrl_d.decimal_add = decimal_add;
		ctrl_d.decimal_sub = decimal_sub;
		ctrl_d.ac_load     = ac_load;
	end

	always_ff @(posedge phi2 or negedge arst_n) begin
		if (!arst_n) begin
			out.valid <= 1'b0;
		end else begin
			out.valid <= op_strobe;
		end
	end

	// Operands only taken with a strobe
	always_ff @(posedge phi2) begin
		if (op_strobe) begin
			out.data  <= operands_d;
			out.ctrl  <= ctrl_d;
			out.carry <= carry_in;
		end
	end

endmodule

`default_nettype wire

// ==== logic/alu_logic_unit.sv ====
`default_nettype none

`include "alu_macros.svh"

module alu_logic_unit (
	input  logic     phi2,
	input  logic     arst_n,
	alu_stage_if.dst in,
	alu_stage_if.src out
);
	import alu_pkg::*;

	logic [`ALU_WIDTH-1:0] nands;
	logic [`ALU_WIDTH-1:0] nors;
	logic [`ALU_WIDTH-1:0] xors;
	logic [`ALU_WIDTH-1:0] sums;
	logic [`ALU_WIDTH-1:0] cout;
	logic                  c_prev;
	logic                  daa;
	logic                  dc3;
	logic                  dc7;
	logic                  avr_d;
	logic                  acr_d;
	alu_sum_t              sum_d;

	assign nands = ~(in.data.ai & in.data.bi);
	assign nors  = ~(in.data.ai | in.data.bi);
	assign xors  = in.data.ai ^ in.data.bi;

	// Decimal carries only take part in a decimal add
	assign daa = in.ctrl.decimal_add && (in.ctrl.op == op_sum);

	// Ripple chain, DC3 forced in at the top of the low digit
	always_comb begin
		c_prev = in.carry;
		dc3    = 1'b0;
		for (int i = 0; i < `ALU_WIDTH; i++) begin
			sums[i] = xors[i] ^ c_prev;
			cout[i] = ~nands[i] | (~nors[i] & c_prev);
			if (i == `ALU_NIBBLE - 1) begin
				dc3     = daa && (sums[`ALU_NIBBLE-1:0] > `ALU_BCD_MAX);
				cout[i] = cout[i] | dc3;
			end
			c_prev = cout[i];
		end
	end

	// Upper digit above 9, from the propagate terms and the chain
	assign dc7 = daa && (sums[`ALU_WIDTH-1 -: `ALU_NIBBLE] > `ALU_BCD_MAX);

	// Both inputs equal in bit 7 and carry into bit 7 differs from them
	assign avr_d = (cout[`ALU_WIDTH-2] & nors[`ALU_WIDTH-1]) |
		(~cout[`ALU_WIDTH-2] & ~nands[`ALU_WIDTH-1]);

	always_comb begin
		sum_d.res        = '0;
		sum_d.half_carry = 1'b0;
		sum_d.avr        = 1'b0;
		acr_d            = 1'b0;
		case (in.ctrl.op)
			op_and: sum_d.res = ~nands;
			op_or:  sum_d.res = ~nors;
			op_eor: sum_d.res = xors;
			op_sum: begin
				sum_d.res        = sums;
				sum_d.half_carry = cout[`ALU_NIBBLE-1];
				sum_d.avr        = avr_d;
				acr_d            = cout[`ALU_WIDTH-1] | dc7;
			end
			op_sr: begin
				sum_d.res = {1'b0, ~nands[`ALU_WIDTH-1:1]};
				acr_d     = ~nands[0]; // bit shifted out
			end
			default: sum_d.res = '0;
		endcase
	end

	always_ff @(posedge phi2 or negedge arst_n) begin
		if (!arst_n) begin
			out.valid <= 1'b0;
		end else begin
			out.valid <= in.valid;
		end
	end

	always_ff @(posedge phi2) begin
		if (in.valid) begin
			out.data  <= sum_d;
			out.ctrl  <= in.ctrl;
			out.carry <= acr_d;
		end
	end

endmodule

`default_nettype wire

// ==== logic/alu_bcd_adjust.sv ====
`default_nettype none

`include "alu_macros.svh"

module alu_bcd_adjust (
	input  logic                  phi2,
	input  logic                  arst_n,
	alu_stage_if.dst              in,
	output logic                  result_strobe,
	output logic [`ALU_WIDTH-1:0] result,
	output logic                  acr,
	output logic                  avr,
	output logic [`ALU_WIDTH-1:0] ac
);
	import alu_pkg::*;

	localparam int digits = `ALU_WIDTH / `ALU_NIBBLE;

	// Gap between a nibble and a BCD digit
	localparam logic [`ALU_NIBBLE-1:0] bcd_fix = `ALU_NIBBLE'd15 - `ALU_NIBBLE'd`ALU_BCD_MAX;

	logic                  daa;
	logic                  dsa;
	logic [digits-1:0]     digit_carry;
	logic [`ALU_WIDTH-1:0] adj_d;

	assign daa = in.ctrl.decimal_add && (in.ctrl.op == op_sum);
	assign dsa = in.ctrl.decimal_sub && (in.ctrl.op == op_sum);

	// Low digit from the half carry, high digit from acr
	assign digit_carry = {in.carry, in.data.half_carry};

	always_comb begin
		adj_d = in.data.res;
		for (int n = 0; n < digits; n++) begin
			if (daa && digit_carry[n]) begin
				adj_d[n*`ALU_NIBBLE +: `ALU_NIBBLE] =
					adj_d[n*`ALU_NIBBLE +: `ALU_NIBBLE] + bcd_fix;
			end else if (dsa && !digit_carry[n]) begin
				// Borrow from this digit, wraps mod 16
				adj_d[n*`ALU_NIBBLE +: `ALU_NIBBLE] =
					adj_d[n*`ALU_NIBBLE +: `ALU_NIBBLE] - bcd_fix;
			end
		end
	end

	always_ff @(posedge phi2 or negedge arst_n) begin
		if (!arst_n) begin
			result_strobe <= 1'b0;
			result        <= '0;
			acr           <= 1'b0;
			avr           <= 1'b0;
			ac            <= '0;
		end else begin
			result_strobe <= in.valid;
			if (in.valid) begin // Hold until the next result
				result <= adj_d;
				acr    <= in.carry;
				avr    <= in.data.avr;
				if (in.ctrl.ac_load) begin
					ac <= adj_d;
				end
			end
		end
	end

endmodule

`default_nettype wire

// ==== logic/alu_core.sv ====
`default_nettype none

`include "alu_macros.svh"

module alu_core (
	input  logic                  phi2,
	input  logic                  arst_n,
	input  logic                  op_strobe,
	input  alu_pkg::alu_op_t      op,
	input  logic                  ai_zero,
	input  alu_pkg::alu_bsrc_t    bsrc,
	input  logic [`ALU_WIDTH-1:0] sb,
	input  logic [`ALU_WIDTH-1:0] db,
	input  logic [`ALU_WIDTH-1:0] adl,
	input  logic                  carry_in,
	input  logic                  decimal_add,
	input  logic                  decimal_sub,
	input  logic                  ac_load,
	output logic                  result_strobe,
	output logic [`ALU_WIDTH-1:0] result,
	output logic                  acr,
	output logic                  avr,
	output logic [`ALU_WIDTH-1:0] ac
);
	import alu_pkg::*;

	alu_stage_if #(.data_t(alu_operands_t)) op_if ();  // carry is carry_in
	alu_stage_if #(.data_t(alu_sum_t))      res_if (); // carry is acr

	alu_operand_latch u_operand_latch (
		.phi2        (phi2),
		.arst_n      (arst_n),
		.op_strobe   (op_strobe),
		.op          (op),
		.ai_zero     (ai_zero),
		.bsrc        (bsrc),
		.sb          (sb),
		.db          (db),
		.adl         (adl),
		.carry_in    (carry_in),
		.decimal_add (decimal_add),
		.decimal_sub (decimal_sub),
		.ac_load     (ac_load),
		.out         (op_if.src)
	);

	alu_logic_unit u_logic_unit (
		.phi2   (phi2),
		.arst_n (arst_n),
		.in     (op_if.dst),
		.out    (res_if.src)
	);

	alu_bcd_adjust u_bcd_adjust (
		.phi2          (phi2),
		.arst_n        (arst_n),
		.in            (res_if.dst),
		.result_strobe (result_strobe),
		.result        (result),
		.acr           (acr),
		.avr           (avr),
		.ac            (ac)
	);

endmodule

`default_nettype wire

// ==== verif/alu_core_assert.sv ====
`default_nettype none

`include "alu_macros.svh"

module alu_core_assert (
	input logic                  phi2,
	input logic                  arst_n,
	input logic                  op_strobe,
	input logic                  ac_load,
	input logic                  result_strobe,
	input logic [`ALU_WIDTH-1:0] result,
	input logic                  acr,
	input logic                  avr,
	input logic [`ALU_WIDTH-1:0] ac
);
	timeunit 1ns;
	timeprecision 1ps;

	int error_count = 0;

	// Three sampled cycles from strobe to result
	a_result_follows: assert property (@(posedge phi2) disable iff (!arst_n)
		op_strobe |-> ##3 result_strobe)
		else begin
			$error("result_strobe missing three cycles after op_strobe");
			error_count++;
		end

	a_no_stray_result: assert property (@(posedge phi2) disable iff (!arst_n)
		result_strobe |-> $past(op_strobe, 3))
		else begin
			$error("result_strobe without a matching op_strobe");
			error_count++;
		end

	a_ac_only_on_load: assert property (@(posedge phi2) disable iff (!arst_n)
		!$stable(ac) |-> $past(op_strobe && ac_load, 3))
		else begin
			$error("ac changed without an ac_load result");
			error_count++;
		end

	a_reset_clears: assert property (@(posedge phi2)
		!arst_n |-> (!result_strobe && !acr && !avr && result == '0 && ac == '0))
		else begin
			$error("Outputs not cleared during reset");
			error_count++;
		end

endmodule

`default_nettype wire

// ==== verif/alu_core_tb.sv ====
`default_nettype none

`include "alu_macros.svh"

module alu_core_tb;
	timeunit 1ns;
	timeprecision 1ps;

	import alu_pkg::*;

	localparam int timeout_cycles = 20;
	localparam int latency        = 3; // From driving op_strobe to seeing result_strobe

	typedef struct packed {
		logic [`ALU_WIDTH-1:0] result;
		logic                  acr;
		logic                  avr;
		logic                  ac_load;
		logic [31:0]           cycle;
	} expect_t;

	logic                  phi2;
	logic                  arst_n;
	logic                  op_strobe;
	alu_op_t               op;
	logic                  ai_zero;
	alu_bsrc_t             bsrc;
	logic [`ALU_WIDTH-1:0] sb;
	logic [`ALU_WIDTH-1:0] db;
	logic [`ALU_WIDTH-1:0] adl;
	logic                  carry_in;
	logic                  decimal_add;
	logic                  decimal_sub;
	logic                  ac_load;
	logic                  result_strobe;
	logic [`ALU_WIDTH-1:0] result;
	logic                  acr;
	logic                  avr;
	logic [`ALU_WIDTH-1:0] ac;

	expect_t               exp_q[$];
	logic [`ALU_WIDTH-1:0] ac_model;
	int                    cycle_cnt = 0;
	string                 test_name;

	alu_core dut (
		.phi2          (phi2),
		.arst_n        (arst_n),
		.op_strobe     (op_strobe),
		.op            (op),
		.ai_zero       (ai_zero),
		.bsrc          (bsrc),
		.sb            (sb),
		.db            (db),
		.adl           (adl),
		.carry_in      (carry_in),
		.decimal_add   (decimal_add),
		.decimal_sub   (decimal_sub),
		.ac_load       (ac_load),
		.result_strobe (result_strobe),
		.result        (result),
		.acr           (acr),
		.avr           (avr),
		.ac            (ac)
	);

	bind alu_core alu_core_assert u_core_assert (
		.phi2          (phi2),
		.arst_n        (arst_n),
		.op_strobe     (op_strobe),
		.ac_load       (ac_load),
		.result_strobe (result_strobe),
		.result        (result),
		.acr           (acr),
		.avr           (avr),
		.ac            (ac)
	);

	initial begin
		phi2 = 1'b0;
		forever #20 phi2 = ~phi2;
	end

	always @(posedge phi2) cycle_cnt <= cycle_cnt + 1;

	always @(posedge phi2) begin
		if (dut.u_core_assert.error_count != 0) begin
			$display("Test %s: a bound assertion failed", test_name);
			$display(">>> FAIL");
			$fatal(1, "Assertion failed");
		end
	end

	task automatic check_eq(input string what, input logic [31:0] expected,
		input logic [31:0] actual);
		if (actual !== expected) begin
			$display("Fail %s %s: expected %0h, actual %0h", test_name, what, expected, actual);
			$display(">>> FAIL");
			$fatal(1, "Stopped at the first mismatch");
		end
	endtask

	task automatic wait_result();
		int n;
		n = 0;
		while (result_strobe !== 1'b1 && n < timeout_cycles) begin
			@(posedge phi2);
			#2;
			n++;
		end
		if (result_strobe !== 1'b1) begin
			$display("Test %s: no result_strobe within %0d cycles", test_name, timeout_cycles);
			$display(">>> FAIL");
			$fatal(1, "Result never arrived");
		end
	endtask

	function automatic logic [7:0] rand_byte();
		logic [31:0] r;
		r = $urandom;
		return r[7:0];
	endfunction

	function automatic logic rand_bit();
		logic [31:0] r;
		r = $urandom;
		return r[0];
	endfunction

	function automatic logic [7:0] int_to_bcd(int v);
		logic [3:0] tens;
		logic [3:0] ones;
		tens = v / 10;
		ones = v % 10;
		return {tens, ones};
	endfunction

	function automatic int bcd_to_int(logic [7:0] v);
		return v[7:4] * 10 + v[3:0];
	endfunction

	function automatic logic [7:0] rand_bcd();
		return int_to_bcd($urandom % 100);
	endfunction

	function automatic alu_bsrc_t pick_bsrc(int i);
		case (i % 3)
			0:       return bsrc_db;
			1:       return bsrc_ndb;
			default: return bsrc_adl;
		endcase
	endfunction

	function automatic alu_op_t pick_op(int i);
		case (i % 5)
			0:       return op_and;
			1:       return op_or;
			2:       return op_eor;
			3:       return op_sr;
			default: return op_sum;
		endcase
	endfunction

	function automatic logic [7:0] select_bi(alu_bsrc_t src, logic [7:0] dbv, logic [7:0] adlv);
		case (src)
			bsrc_ndb: return ~dbv;
			bsrc_adl: return adlv;
			default:  return dbv;
		endcase
	endfunction

	function automatic expect_t model_op(alu_op_t opv, logic [7:0] ai, logic [7:0] bi,
		logic cin, logic dadd, logic dsub, logic acl);
		expect_t    e;
		logic [8:0] sum9;
		logic [7:0] anded;
		logic [4:0] low_sum;
		logic [4:0] high_sum;
		int         dec;
		e           = '0;
		e.ac_load   = acl;
		case (opv)
			op_and: e.result = ai & bi;
			op_or:  e.result = ai | bi;
			op_eor: e.result = ai ^ bi;
			op_sr: begin
				anded    = ai & bi;
				e.result = anded >> 1;
				e.acr    = anded[0];
			end
			op_sum: begin
				sum9     = ai + bi + cin;
				e.result = sum9[7:0];
				e.acr    = sum9[8];
				e.avr    = (ai[7] == bi[7]) && (sum9[7] != ai[7]);
				if (dadd) begin
					dec      = bcd_to_int(ai) + bcd_to_int(bi) + cin;
					e.acr    = dec > 99;
					e.result = int_to_bcd(dec % 100);
					// V taken after the low digit fix
					low_sum  = ai[3:0] + bi[3:0] + cin;
					high_sum = ai[7:4] + bi[7:4] + (low_sum > 9);
					e.avr    = (ai[7] == bi[7]) && (high_sum[3] != ai[7]);
				end else if (dsub) begin
					dec      = bcd_to_int(ai) - bcd_to_int(~bi) - (cin ? 0 : 1);
					e.acr    = dec >= 0; // No borrow
					e.result = int_to_bcd(dec < 0 ? dec + 100 : dec);
				end
			end
			default: e.result = 8'h00;
		endcase
		return e;
	endfunction

	task automatic issue_op(alu_op_t opv, logic zero, alu_bsrc_t src, logic [7:0] sbv,
		logic [7:0] dbv, logic [7:0] adlv, logic cin, logic dadd, logic dsub, logic acl);
		expect_t e;
		e = model_op(opv, zero ? 8'h00 : sbv, select_bi(src, dbv, adlv), cin, dadd, dsub, acl);
		e.cycle = cycle_cnt;
		exp_q.push_back(e);
		op          = opv;
		ai_zero     = zero;
		bsrc        = src;
		sb          = sbv;
		db          = dbv;
		adl         = adlv;
		carry_in    = cin;
		decimal_add = dadd;
		decimal_sub = dsub;
		ac_load     = acl;
		op_strobe   = 1'b1;
		@(posedge phi2);
		#2;
		op_strobe = 1'b0;
		ac_load   = 1'b0;
	endtask

	task automatic collect_result();
		expect_t e;
		wait_result();
		e = exp_q.pop_front();
		if (e.ac_load) begin
			ac_model = e.result;
		end
		check_eq("result", e.result, result);
		check_eq("acr", e.acr, acr);
		check_eq("avr", e.avr, avr);
		check_eq("ac", ac_model, ac);
		check_eq("latency", e.cycle + latency, cycle_cnt);
		@(posedge phi2);
		#2;
	endtask

	task automatic test_reset();
		test_name = "reset";
		check_eq("result_strobe", 0, result_strobe);
		check_eq("result", 0, result);
		check_eq("acr", 0, acr);
		check_eq("avr", 0, avr);
		check_eq("ac", 0, ac);
	endtask

	task automatic test_logic_ops();
		test_name = "logic_ops";
		for (int i = 0; i < 48; i++) begin
			issue_op(pick_op(i % 4), ($urandom % 4) == 0, pick_bsrc(i), rand_byte(),
				rand_byte(), rand_byte(), rand_bit(), 1'b0, 1'b0, rand_bit());
			collect_result();
		end
	endtask

	task automatic test_binary();
		test_name = "binary";
		for (int i = 0; i < 64; i++) begin
			issue_op(op_sum, 1'b0, (i < 32) ? bsrc_db : bsrc_ndb, rand_byte(), rand_byte(),
				8'h00, rand_bit(), 1'b0, 1'b0, 1'b0);
			collect_result();
		end
		// Signed overflow corners
		issue_op(op_sum, 1'b0, bsrc_db, 8'h7f, 8'h01, 8'h00, 1'b0, 1'b0, 1'b0, 1'b0);
		collect_result();
		issue_op(op_sum, 1'b0, bsrc_db, 8'h80, 8'hff, 8'h00, 1'b0, 1'b0, 1'b0, 1'b0);
		collect_result();
		issue_op(op_sum, 1'b0, bsrc_db, 8'hff, 8'h00, 8'h00, 1'b1, 1'b0, 1'b0, 1'b0);
		collect_result();
		issue_op(op_sum, 1'b0, bsrc_ndb, 8'h80, 8'h01, 8'h00, 1'b1, 1'b0, 1'b0, 1'b0);
		collect_result();
		issue_op(op_sum, 1'b0, bsrc_ndb, 8'h7f, 8'hff, 8'h00, 1'b1, 1'b0, 1'b0, 1'b0);
		collect_result();
		issue_op(op_sum, 1'b0, bsrc_ndb, 8'h00, 8'h01, 8'h00, 1'b1, 1'b0, 1'b0, 1'b0);
		collect_result();
	endtask

	task automatic test_decimal();
		test_name = "decimal";
		for (int i = 0; i < 64; i++) begin
			issue_op(op_sum, 1'b0, (i < 32) ? bsrc_db : bsrc_ndb, rand_bcd(), rand_bcd(),
				8'h00, rand_bit(), i < 32, i >= 32, rand_bit());
			collect_result();
		end
		issue_op(op_sum, 1'b0, bsrc_db, 8'h99, 8'h01, 8'h00, 1'b0, 1'b1, 1'b0, 1'b0);
		collect_result();
		issue_op(op_sum, 1'b0, bsrc_db, 8'h99, 8'h99, 8'h00, 1'b1, 1'b1, 1'b0, 1'b0);
		collect_result();
		issue_op(op_sum, 1'b0, bsrc_ndb, 8'h00, 8'h01, 8'h00, 1'b1, 1'b0, 1'b1, 1'b0);
		collect_result();
		issue_op(op_sum, 1'b0, bsrc_ndb, 8'h50, 8'h50, 8'h00, 1'b0, 1'b0, 1'b1, 1'b0);
		collect_result();
	endtask

	task automatic test_pipeline();
		test_name = "pipeline";
		fork
			for (int i = 0; i < 16; i++) begin
				issue_op(pick_op($urandom % 5), 1'b0, pick_bsrc(i), rand_byte(), rand_byte(),
					rand_byte(), rand_bit(), 1'b0, 1'b0, rand_bit());
			end
			for (int j = 0; j < 16; j++) begin
				collect_result();
			end
		join
		check_eq("ac held", ac_model, ac);
		check_eq("idle strobe", 0, result_strobe);
	endtask

	initial begin
		void'($urandom(32'h32e27557));
		ac_model    = '0;
		arst_n      = 1'b1;
		op_strobe   = 1'b0;
		op          = op_and;
		ai_zero     = 1'b0;
		bsrc        = bsrc_db;
		sb          = '0;
		db          = '0;
		adl         = '0;
		carry_in    = 1'b0;
		decimal_add = 1'b0;
		decimal_sub = 1'b0;
		ac_load     = 1'b0;
		#1;
		arst_n = 1'b0; // Falling edge clears the registers before the first clock
		repeat (5) @(posedge phi2);
		#2;
		arst_n = 1'b1;
		test_reset();
		test_logic_ops();
		test_binary();
		test_decimal();
		test_pipeline();
		if (dut.u_core_assert.error_count == 0) begin
			$display(">>> PASS");
		end else begin
			$display(">>> FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== files.f ====
+incdir+include
logic/alu_pkg.sv
logic/alu_stage_if.sv
logic/alu_operand_latch.sv
logic/alu_logic_unit.sv
logic/alu_bcd_adjust.sv
logic/alu_core.sv
verif/alu_core_assert.sv
verif/alu_core_tb.sv
